//--- hw/mult_controller.sv
`include "mult_params.svh"

module mult_controller (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    valid_src,
    output logic                    ready_src,
    output logic                    valid_dst,
    input  logic                    ready_dst,
    output mult_ctrl_pkg::pp_ctrl_t ctrl
);

    import mult_types_pkg::*;
    import mult_ctrl_pkg::*;

    mult_state_e state;
    mult_state_e state_next;
    step_t       count;
    logic        accept;
    logic        deliver;
    logic        last_step;

    //////////////////////////////
    // Handshake events
    //////////////////////////////

    // Operand taken from the source
    assign accept = valid_src && ready_src;
    // Product taken by the sink
    assign deliver = valid_dst && ready_dst;

    // Final step carries the sign bit
    assign last_step = (count == step_t'(`MULT_STEPS - 1));

    //////////////////////////////
    // State machine
    //////////////////////////////

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (accept) begin
                    state_next = STEP;
                end
            end
            STEP: begin
                // Exactly 16 cycles here
                if (last_step) begin
                    state_next = DONE;
                end
            end
            DONE: begin
                // Hold under back-pressure
                if (deliver) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    // Step counter, runs 0 to 15 in STEP, rests at 0 elsewhere
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            count <= '0;
        end else if ((state == STEP) && !last_step) begin
            count <= count + step_t'(1);
        end else begin
            count <= '0;
        end
    end

    //////////////////////////////
    // Outputs
    //////////////////////////////

    assign ready_src = (state == IDLE);
    assign valid_dst = (state == DONE);

    always_comb begin
        // Load on accept, and again when the product leaves
        // so the accumulator is cleared once it is taken
        ctrl.load       = ((state == IDLE) && valid_src) || deliver;
        ctrl.accumulate = (state == STEP);
        ctrl.negate     = (state == STEP) && last_step;
        ctrl.step       = count;
    end

endmodule

//--- hw/mult_ctrl_pkg.sv
package mult_ctrl_pkg;

    //////////////////////////////
    // Controller state
    //////////////////////////////

    // IDLE waits for an operand
    // STEP adds one partial product per cycle
    // DONE holds the product until taken
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        STEP = 2'd1,
        DONE = 2'd2
    } mult_state_e;

    //////////////////////////////
    // Controls to the datapath
    //////////////////////////////

    typedef struct packed {
        // Capture multiplicand, clear accumulator
        logic                  load;
        // Add this cycle's partial product
        logic                  accumulate;
        // Sign bit of the multiplier, negative weight
        logic                  negate;
        // Bit index and shift amount
        mult_types_pkg::step_t step;
    } pp_ctrl_t;

endpackage

//--- hw/mult_datapath.sv
module mult_datapath (
    input  logic                     clk,
    input  logic                     reset,
    input  mult_ctrl_pkg::pp_ctrl_t  ctrl,
    input  mult_types_pkg::operand_t multiplicand,
    input  logic                     multiplier_bit,
    output mult_types_pkg::product_t product
);

    import mult_types_pkg::*;

    operand_t multiplicand_q;
    product_t acc_q;
    product_t partial;

    //////////////////////////////
    // Multiplicand register
    //////////////////////////////

    // Captured once on accept
    // Later changes on the input are ignored
    always_ff @(posedge clk) begin
        if (ctrl.load) begin
            multiplicand_q <= multiplicand;
        end
    end

    //////////////////////////////
    // Partial product
    //////////////////////////////

    partial_product_gen u_pp (
        .multiplicand_q (multiplicand_q),
        .multiplier_bit (multiplier_bit),
        .ctrl           (ctrl),
        .partial        (partial)
    );

    //////////////////////////////
    // Accumulator
    //////////////////////////////

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            acc_q <= '0;
        end else if (ctrl.load) begin
            // Fresh sum for the next operand
            acc_q <= '0;
        end else if (ctrl.accumulate) begin
            acc_q <= acc_q + partial;
        end
        // Held otherwise, stable through DONE
    end

    assign product = acc_q;

endmodule

//--- hw/mult_params.svh
`ifndef MULT_PARAMS_SVH
`define MULT_PARAMS_SVH

//////////////////////////////
// Operand and product widths
//////////////////////////////

// Signed multiplicand, parallel input
`define MULT_OPERAND_W 16
// Full signed product, never truncated
`define MULT_PRODUCT_W 32

//////////////////////////////
// Serial sequencing
//////////////////////////////

// Step index, doubles as the shift amount
`define MULT_STEP_W 5
// One step per multiplier bit
`define MULT_STEPS 16

`endif

//--- hw/mult_types_pkg.sv
`include "mult_params.svh"

package mult_types_pkg;

    //////////////////////////////
    // Data widths
    //////////////////////////////

    // Two's complement multiplicand
    typedef logic signed [`MULT_OPERAND_W-1:0] operand_t;

    // Accumulator and final product
    // Wide enough for the extreme negative square
    typedef logic signed [`MULT_PRODUCT_W-1:0] product_t;

    // Index of the current multiplier bit
    // Same value as the partial-product shift
    typedef logic [`MULT_STEP_W-1:0] step_t;

endpackage

//--- hw/partial_product_gen.sv
`include "mult_params.svh"

module partial_product_gen (
    input  mult_types_pkg::operand_t multiplicand_q,
    input  logic                     multiplier_bit,
    input  mult_ctrl_pkg::pp_ctrl_t  ctrl,
    output mult_types_pkg::product_t partial
);

    import mult_types_pkg::*;

    product_t extended;
    product_t gated;
    product_t weighted;

    //////////////////////////////
    // Partial product
    //////////////////////////////

    // Sign extend to product width
    assign extended = {
        {(`MULT_PRODUCT_W - `MULT_OPERAND_W){multiplicand_q[`MULT_OPERAND_W-1]}},
        multiplicand_q
    };

    // Zero when the multiplier bit is clear
    assign gated = multiplier_bit ? extended : '0;

    // Sign bit of the multiplier has weight -2^15
    // Two's complement turns the add into a subtract
    assign weighted = ctrl.negate ? -gated : gated;

    // Align to the bit position
    assign partial = weighted << ctrl.step;

endmodule

//--- hw/seq_multiplier.sv
module seq_multiplier (
    input  logic                     clk,
    input  logic                     reset,
    // Operand side
    input  logic                     valid_src,
    output logic                     ready_src,
    input  mult_types_pkg::operand_t multiplicand,
    // Serial multiplier, LSB first from the accept edge
    input  logic                     multiplier_bit,
    // Product side
    output logic                     valid_dst,
    input  logic                     ready_dst,
    output mult_types_pkg::product_t product
);

    import mult_ctrl_pkg::*;

    // Sequencing controls to the datapath
    pp_ctrl_t ctrl;

    //////////////////////////////
    // Controller
    //////////////////////////////

    // Handshakes and step count
    // Never looks at the multiplier bit
    mult_controller u_ctrl (
        .clk       (clk),
        .reset     (reset),
        .valid_src (valid_src),
        .ready_src (ready_src),
        .valid_dst (valid_dst),
        .ready_dst (ready_dst),
        .ctrl      (ctrl)
    );

    //////////////////////////////
    // Datapath
    //////////////////////////////

    // Multiplicand register and accumulator
    mult_datapath u_dp (
        .clk            (clk),
        .reset          (reset),
        .ctrl           (ctrl),
        .multiplicand   (multiplicand),
        .multiplier_bit (multiplier_bit),
        .product        (product)
    );

endmodule

//--- list.f
+incdir+hw
hw/mult_types_pkg.sv
hw/mult_ctrl_pkg.sv
hw/partial_product_gen.sv
hw/mult_controller.sv
hw/mult_datapath.sv
hw/seq_multiplier.sv
tests/seq_multiplier_sva.sv
tests/seq_multiplier_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the sequential multiplier testbench with Verilator
# Result comes from a search of the log

LOG=sim.log
FAIL_MSG="Checks failed"

rm -rf obj_dir "$LOG"

verilator --binary --assert --top-module seq_multiplier_tb -f list.f \
    -o sim_seq_multiplier > "$LOG" 2>&1 \
    && ./obj_dir/sim_seq_multiplier >> "$LOG" 2>&1 \
    || echo "$FAIL_MSG" >> "$LOG"

cat "$LOG"

grep -q "$FAIL_MSG" "$LOG" \
    && { echo "FAIL"; exit 1; } \
    || { echo "PASS"; exit 0; }

//--- tests/seq_multiplier_sva.sv
`include "mult_params.svh"

module seq_multiplier_sva (
    input logic                     clk,
    input logic                     reset,
    input logic                     valid_src,
    input logic                     ready_src,
    input logic                     valid_dst,
    input logic                     ready_dst,
    input mult_types_pkg::product_t product
);

    logic accept;

    // Number of assertion failures
    int failures = 0;

    assign accept = valid_src && ready_src;

    //////////////////////////////
    // Handshake properties
    //////////////////////////////

    // Source side reopens only after the product is taken
    property source_reopens_after_transfer;
        @(posedge clk) disable iff (!reset)
            $rose(ready_src) |-> $past(valid_dst && ready_dst);
    endproperty

    // Product and valid hold while the sink is busy
    property product_held;
        @(posedge clk) disable iff (!reset)
            (valid_dst && !ready_dst) |=> (valid_dst && $stable(product));
    endproperty

    // Rise of valid_dst lines up with an accept 16 edges before
    property fixed_latency;
        @(posedge clk) disable iff (!reset)
            $rose(valid_dst) == $past(accept, `MULT_STEPS + 1);
    endproperty

    a_source_reopens_after_transfer: assert property (source_reopens_after_transfer) else begin
        $error("ready_src rose without an output transfer");
        failures = failures + 1;
    end

    a_product_held: assert property (product_held) else begin
        $error("product or valid_dst changed under back-pressure");
        failures = failures + 1;
    end

    a_fixed_latency: assert property (fixed_latency) else begin
        $error("valid_dst did not rise 16 cycles after accept");
        failures = failures + 1;
    end

endmodule

bind seq_multiplier seq_multiplier_sva u_sva (
    .clk       (clk),
    .reset     (reset),
    .valid_src (valid_src),
    .ready_src (ready_src),
    .valid_dst (valid_dst),
    .ready_dst (ready_dst),
    .product   (product)
);

//--- tests/seq_multiplier_tb.sv
`include "mult_params.svh"

module seq_multiplier_tb;

    import mult_types_pkg::*;

    //////////////////////////////
    // Run limits
    //////////////////////////////

    localparam int ENTRIES       = 12;
    localparam int FIXED_ENTRIES = 8;
    localparam int RESET_CYCLES  = 8;
    // About 21 cycles per entry at worst, 24 leaves slack
    localparam int TIMEOUT_CYCLES = ENTRIES * 24 + RESET_CYCLES + 50;

    // One row of the stimulus table
    typedef struct packed {
        operand_t   multiplicand;
        operand_t   multiplier;
        // Cycles the sink stays busy once valid_dst is up
        logic [1:0] stall;
        product_t   expected;
    } entry_t;

    logic     clk = 1'b0;
    logic     reset;
    logic     valid_src;
    logic     ready_src;
    operand_t multiplicand;
    logic     multiplier_bit;
    logic     valid_dst;
    logic     ready_dst;
    product_t product;

    entry_t table_q [ENTRIES];
    integer seed = 32'hd148;
    int     cycle_count = 0;

    seq_multiplier u_seq_multiplier (
        .clk            (clk),
        .reset          (reset),
        .valid_src      (valid_src),
        .ready_src      (ready_src),
        .multiplicand   (multiplicand),
        .multiplier_bit (multiplier_bit),
        .valid_dst      (valid_dst),
        .ready_dst      (ready_dst),
        .product        (product)
    );

    //////////////////////////////
    // Clock and timeout
    //////////////////////////////

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the DUT never finished the table", cycle_count);
            abort_run();
        end
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    task automatic abort_run();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_value(string name, product_t expected, product_t actual);
        assert (actual === expected) else begin
            $display("[ERROR] time %0t: %s expected %0d (%h), got %0d (%h)",
                     $time, name, expected, expected, actual, actual);
            abort_run();
        end
    endtask

    task automatic check_bit(string name, logic expected, logic actual);
        assert (actual === expected) else begin
            $display("[ERROR] time %0t: %s expected %b, got %b", $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_count(string name, int expected, int actual);
        assert (actual == expected) else begin
            $display("[ERROR] time %0t: %s expected %0d, got %0d", $time, name, expected, actual);
            abort_run();
        end
    endtask

    function automatic operand_t random_operand();
        logic [31:0] rnd;
        rnd = $random(seed);
        return operand_t'(rnd[`MULT_OPERAND_W-1:0]);
    endfunction

    // Expected value is the plain signed product, 32 bits hold every case
    function automatic entry_t make_entry(operand_t a, operand_t b, logic [1:0] stall);
        entry_t e;
        e.multiplicand = a;
        e.multiplier   = b;
        e.stall        = stall;
        e.expected     = product_t'(a) * product_t'(b);
        return e;
    endfunction

    task automatic fill_table();
        operand_t    a;
        operand_t    b;
        logic [31:0] rnd;
        // Corner cases
        table_q[0] = make_entry(16'sd0, -16'sd21846, 2'd0);
        table_q[1] = make_entry(16'sd12345, 16'sd0, 2'd1);
        table_q[2] = make_entry(16'sd1, 16'sh8000, 2'd2);
        table_q[3] = make_entry(-16'sd1, 16'sd1234, 2'd3);
        table_q[4] = make_entry(-16'sd1, -16'sd1, 2'd0);
        table_q[5] = make_entry(16'sh7fff, 16'sh7fff, 2'd1);
        // Both extreme negative cases
        table_q[6] = make_entry(16'sh8000, 16'sh8000, 2'd2);
        table_q[7] = make_entry(16'sh8000, 16'sh7fff, 2'd3);
        // Random operands and stall
        for (int i = FIXED_ENTRIES; i < ENTRIES; i++) begin
            a   = random_operand();
            b   = random_operand();
            rnd = $random(seed);
            table_q[i] = make_entry(a, b, rnd[1:0]);
        end
    endtask

    //////////////////////////////
    // One multiplication
    //////////////////////////////

    // Entered just after a rising edge, left just after the output transfer edge
    task automatic run_entry(input entry_t e);
        product_t held;
        int       cycles;
        valid_src    <= 1'b1;
        multiplicand <= e.multiplicand;
        @(negedge clk);
        check_bit("ready_src", 1'b1, ready_src);
        check_bit("valid_dst", 1'b0, valid_dst);
        // Accumulator starts clean
        check_value("product", '0, product);
        // Accept edge, bit 0 leaves with it
        @(posedge clk);
        valid_src      <= 1'b0;
        // Captured operand must not follow the input
        multiplicand   <= random_operand();
        multiplier_bit <= e.multiplier[0];
        // A sink with no stall is already waiting
        ready_dst      <= (e.stall == 2'd0);
        cycles = 0;
        @(negedge clk);
        // Serial bits, LSB first, until the product shows up
        while (!valid_dst) begin
            check_bit("ready_src", 1'b0, ready_src);
            @(posedge clk);
            cycles = cycles + 1;
            if (cycles < `MULT_STEPS) begin
                multiplier_bit <= e.multiplier[cycles[3:0]];
            end else begin
                multiplier_bit <= 1'b0;
            end
            @(negedge clk);
        end
        check_count("accept to valid_dst cycles", `MULT_STEPS, cycles);
        check_value("product", e.expected, product);
        held = product;
        // Back-pressure, output must hold still
        for (int s = 1; s < int'(e.stall); s++) begin
            @(posedge clk);
            @(negedge clk);
            check_bit("valid_dst", 1'b1, valid_dst);
            check_bit("ready_src", 1'b0, ready_src);
            check_value("product", held, product);
        end
        if (e.stall != 2'd0) begin
            @(posedge clk);
            ready_dst <= 1'b1;
            @(negedge clk);
            check_bit("valid_dst", 1'b1, valid_dst);
            check_value("product", held, product);
        end
        // Output transfer edge
        @(posedge clk);
        ready_dst <= 1'b0;
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        reset          = 1'b0;
        valid_src      = 1'b0;
        multiplicand   = '0;
        multiplier_bit = 1'b0;
        ready_dst      = 1'b0;
        fill_table();
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b1;
        @(negedge clk);
        check_bit("ready_src", 1'b1, ready_src);
        check_bit("valid_dst", 1'b0, valid_dst);
        @(posedge clk);
        // Back to back, next operand offered on the transfer edge
        for (int i = 0; i < ENTRIES; i++) begin
            run_entry(table_q[i]);
        end
        @(negedge clk);
        check_bit("ready_src", 1'b1, ready_src);
        check_bit("valid_dst", 1'b0, valid_dst);
        check_value("product", '0, product);
        if (u_seq_multiplier.u_sva.failures == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("Bound assertions failed %0d times", u_seq_multiplier.u_sva.failures);
            abort_run();
        end
    end

endmodule
